/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - files:
      - hdl/mem_pkg.sv
      - hdl/mem_axi_if.sv
      - hdl/bank_if.sv
      - hdl/axi_arbiter.sv
      - hdl/bank_router.sv
      - hdl/sram_bank.sv
      - hdl/resp_merge.sv
      - hdl/mem_subsystem.sv
  - target: test
    files:
      - verif/mem_subsystem_properties.sv
      - verif/mem_subsystem_tb.sv

/* hdl/axi_arbiter.sv */
`timescale 1ns/1ps

module axi_arbiter import mem_pkg::*; (
    input  logic              clk,
    input  logic              reset,

    // Instruction fetch client
    input  logic              inst_en,
    input  logic [ADDR_W-1:0] inst_addr,
    output logic              inst_resp,
    output logic [DATA_W-1:0] inst_rdata,

    // Load/store client
    input  logic              data_en,
    input  logic [STRB_W-1:0] data_wen,
    input  logic [ADDR_W-1:0] data_addr,
    input  logic [DATA_W-1:0] data_wdata,
    output logic              data_resp,
    output logic [DATA_W-1:0] data_rdata,

    mem_axi_if.master         axi
);

    localparam logic [2:0] IDLE       = 3'd0;
    localparam logic [2:0] FETCH      = 3'd1;
    localparam logic [2:0] LOAD       = 3'd2;
    localparam logic [2:0] STORE      = 3'd3;
    localparam logic [2:0] WAIT_FETCH = 3'd4;
    localparam logic [2:0] WAIT_LOAD  = 3'd5;
    localparam logic [2:0] WAIT_STORE = 3'd6;

    logic [2:0]        state;
    logic [2:0]        state_nxt;
    addr_u             req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic [STRB_W-1:0] req_strb;

    logic ar_done;
    logic aw_done;
    logic r_fetch;
    logic r_load;
    logic b_store;

    assign ar_done = axi.arvalid && axi.arready;
    assign aw_done = axi.awvalid && axi.awready && axi.wvalid && axi.wready;
    assign r_fetch = axi.rvalid && axi.rid == ID_FETCH;
    assign r_load  = axi.rvalid && axi.rid == ID_DATA;
    assign b_store = axi.bvalid && axi.bid == ID_DATA;

    // --------------------
    // State machine
    // --------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                // Data side wins a tie
                if (data_en && |data_wen) begin
                    state_nxt = STORE;
                end else if (data_en) begin
                    state_nxt = LOAD;
                end else if (inst_en) begin
                    state_nxt = FETCH;
                end
            end
            FETCH:      if (ar_done) state_nxt = WAIT_FETCH;
            LOAD:       if (ar_done) state_nxt = WAIT_LOAD;
            STORE:      if (aw_done) state_nxt = WAIT_STORE;
            WAIT_FETCH: if (r_fetch) state_nxt = IDLE;
            WAIT_LOAD:  if (r_load)  state_nxt = IDLE;
            WAIT_STORE: if (b_store) state_nxt = IDLE;
            default:    state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Capture the request while idle
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            req_addr.flat <= data_en ? data_addr : inst_addr;
            req_wdata     <= data_wdata;
            req_strb      <= data_wen;
        end
    end

    // --------------------
    // AXI channels
    // --------------------
    assign axi.arid    = (state == FETCH) ? ID_FETCH : ID_DATA;
    assign axi.araddr  = req_addr;
    assign axi.arvalid = (state == FETCH) || (state == LOAD);
    assign axi.rready  = (state == WAIT_FETCH) || (state == WAIT_LOAD);

    assign axi.awid    = ID_DATA;
    assign axi.awaddr  = req_addr;
    assign axi.awvalid = (state == STORE);
    assign axi.wdata   = req_wdata;
    assign axi.wstrb   = req_strb;
    assign axi.wvalid  = (state == STORE);
    assign axi.bready  = (state == WAIT_STORE);

    // Client side
    assign inst_rdata = axi.rdata;
    assign data_rdata = axi.rdata;
    assign inst_resp  = (state == WAIT_FETCH) && r_fetch;
    // Store completes towards the client as soon as AW and W are taken
    assign data_resp  = ((state == WAIT_LOAD) && r_load) ||
                        ((state == STORE) && aw_done);

endmodule

/* hdl/bank_if.sv */
`timescale 1ns/1ps

interface bank_if import mem_pkg::*; ();

    // Request side
    logic              req_valid;
    logic              req_ready;
    logic              req_write;
    logic [WORD_W-1:0] row;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
    logic [ID_W-1:0]   req_id;

    // Response side
    logic              resp_valid;
    logic              resp_ready;
    logic              resp_write;
    logic [ID_W-1:0]   resp_id;
    logic [DATA_W-1:0] rdata;

    modport router (
        output req_valid, req_write, row, wdata, strb, req_id,
        input  req_ready
    );

    modport bank (
        input  req_valid, req_write, row, wdata, strb, req_id, resp_ready,
        output req_ready, resp_valid, resp_write, resp_id, rdata
    );

    modport merge (
        input  resp_valid, resp_write, resp_id, rdata,
        output resp_ready
    );

endinterface

/* hdl/bank_router.sv */
`timescale 1ns/1ps

module bank_router import mem_pkg::*; #(
    parameter int NUM_BANKS = 4
) (
    mem_axi_if.slave axi,
    bank_if.router   banks [NUM_BANKS]
);

    localparam int BANK_W = $clog2(NUM_BANKS);

    logic              is_write;
    logic              any_valid;
    addr_u             addr;
    logic [BANK_W-1:0] sel;
    logic [WORD_W-1:0] row_word;
    logic [ID_W-1:0]   id;
    logic [NUM_BANKS-1:0] ready_vec;
    logic              sel_ready;

    // AW and W always arrive together from the arbiter
    assign is_write  = axi.awvalid && axi.wvalid;
    assign any_valid = axi.arvalid || is_write;
    assign addr      = is_write ? axi.awaddr : axi.araddr;
    assign id        = is_write ? axi.awid : axi.arid;

    // Low bank-select bits pick the bank, the rest belongs to the row
    assign sel      = addr.fields.bank_sel[BANK_W-1:0];
    assign row_word = {addr.fields.row, addr.fields.bank_sel} >> BANK_W;

    for (genvar gi = 0; gi < NUM_BANKS; gi++) begin : g_bank
        assign banks[gi].req_valid = any_valid && (sel == gi);
        assign banks[gi].req_write = is_write;
        assign banks[gi].row       = row_word;
        assign banks[gi].wdata     = axi.wdata;
        assign banks[gi].strb      = axi.wstrb;
        assign banks[gi].req_id    = id;
        assign ready_vec[gi]       = banks[gi].req_ready;
    end

    assign sel_ready   = ready_vec[sel];
    assign axi.arready = !is_write && sel_ready;
    assign axi.awready = is_write && sel_ready;
    assign axi.wready  = is_write && sel_ready;

endmodule

/* hdl/mem_axi_if.sv */
`timescale 1ns/1ps

interface mem_axi_if import mem_pkg::*; ();

    // Read address
    logic [ID_W-1:0]   arid;
    addr_u             araddr;
    logic              arvalid;
    logic              arready;

    // Read data
    logic [ID_W-1:0]   rid;
    logic [DATA_W-1:0] rdata;
    logic              rvalid;
    logic              rready;

    // Write address
    logic [ID_W-1:0]   awid;
    addr_u             awaddr;
    logic              awvalid;
    logic              awready;

    // Write data, single beat
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              wvalid;
    logic              wready;

    // Write response
    logic [ID_W-1:0]   bid;
    logic              bvalid;
    logic              bready;

    modport master (
        output arid, araddr, arvalid, rready, awid, awaddr, awvalid,
        output wdata, wstrb, wvalid, bready,
        input  arready, rid, rdata, rvalid, awready, wready, bid, bvalid
    );

    modport slave (
        input  arid, araddr, arvalid, rready, awid, awaddr, awvalid,
        input  wdata, wstrb, wvalid, bready,
        output arready, rid, rdata, rvalid, awready, wready, bid, bvalid
    );

endinterface

/* hdl/mem_pkg.sv */
package mem_pkg;

    // --------------------
    // Bus widths
    // --------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W   = 4;

    // Byte offset, bank select and row fields of an address
    localparam int OFFSET_W = 3;
    localparam int BSEL_W   = 4;
    localparam int ROW_W    = ADDR_W - BSEL_W - OFFSET_W;
    localparam int WORD_W   = ADDR_W - OFFSET_W;

    // --------------------
    // Transfer IDs
    // --------------------
    localparam logic [ID_W-1:0] ID_FETCH = ID_W'(0);
    localparam logic [ID_W-1:0] ID_DATA  = ID_W'(1);

    typedef struct packed {
        logic [ROW_W-1:0]    row;
        logic [BSEL_W-1:0]   bank_sel;
        logic [OFFSET_W-1:0] offset;
    } addr_fields_t;

    // Flat byte address for the clients, field view for the banks
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        addr_fields_t      fields;
    } addr_u;

endpackage

/* hdl/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem import mem_pkg::*; #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_DEPTH = 64
) (
    input  logic              clk,
    input  logic              reset,

    input  logic              inst_en,
    input  logic [ADDR_W-1:0] inst_addr,
    output logic              inst_resp,
    output logic [DATA_W-1:0] inst_rdata,

    input  logic              data_en,
    input  logic [STRB_W-1:0] data_wen,
    input  logic [ADDR_W-1:0] data_addr,
    input  logic [DATA_W-1:0] data_wdata,
    output logic              data_resp,
    output logic [DATA_W-1:0] data_rdata
);

    mem_axi_if axi ();
    bank_if    banks [NUM_BANKS] ();

    axi_arbiter axi_arbiter_i (
        .clk        (clk),
        .reset      (reset),
        .inst_en    (inst_en),
        .inst_addr  (inst_addr),
        .inst_resp  (inst_resp),
        .inst_rdata (inst_rdata),
        .data_en    (data_en),
        .data_wen   (data_wen),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_resp  (data_resp),
        .data_rdata (data_rdata),
        .axi        (axi)
    );

    bank_router #(.NUM_BANKS(NUM_BANKS)) bank_router_i (
        .axi   (axi),
        .banks (banks)
    );

    // --------------------
    // Bank array
    // --------------------
    for (genvar gi = 0; gi < NUM_BANKS; gi++) begin : g_bank
        sram_bank #(.BANK_DEPTH(BANK_DEPTH)) sram_bank_i (
            .clk   (clk),
            .reset (reset),
            .port  (banks[gi])
        );
    end

    resp_merge #(.NUM_BANKS(NUM_BANKS)) resp_merge_i (
        .clk   (clk),
        .reset (reset),
        .banks (banks),
        .axi   (axi)
    );

endmodule

/* hdl/resp_merge.sv */
`timescale 1ns/1ps

module resp_merge import mem_pkg::*; #(
    parameter int NUM_BANKS = 4
) (
    input  logic     clk,
    input  logic     reset,
    bank_if.merge    banks [NUM_BANKS],
    mem_axi_if.slave axi
);

    localparam int BANK_W = $clog2(NUM_BANKS);

    logic [NUM_BANKS-1:0] bank_valid;
    logic [NUM_BANKS-1:0] bank_write;
    logic [ID_W-1:0]      bank_id   [NUM_BANKS];
    logic [DATA_W-1:0]    bank_data [NUM_BANKS];

    logic [BANK_W-1:0] pick;
    logic              any;
    logic              accept;
    logic              drain;
    logic              hold_valid;
    logic              hold_write;
    logic [ID_W-1:0]   hold_id;
    logic [DATA_W-1:0] hold_data;

    for (genvar gi = 0; gi < NUM_BANKS; gi++) begin : g_bank
        assign bank_valid[gi]       = banks[gi].resp_valid;
        assign bank_write[gi]       = banks[gi].resp_write;
        assign bank_id[gi]          = banks[gi].resp_id;
        assign bank_data[gi]        = banks[gi].rdata;
        assign banks[gi].resp_ready = accept && (pick == gi);
    end

    // Lowest-numbered bank first
    always_comb begin
        pick = '0;
        any  = 1'b0;
        for (int i = NUM_BANKS - 1; i >= 0; i--) begin
            if (bank_valid[i]) begin
                pick = BANK_W'(i);
                any  = 1'b1;
            end
        end
    end

    assign accept = !hold_valid && any;
    assign drain  = (axi.rvalid && axi.rready) || (axi.bvalid && axi.bready);

    // --------------------
    // Hold register
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            hold_valid <= 1'b0;
        end else if (accept) begin
            hold_valid <= 1'b1;
        end else if (drain) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hold_write <= bank_write[pick];
            hold_id    <= bank_id[pick];
            hold_data  <= bank_data[pick];
        end
    end

    // Same entry shows up on R or on B
    assign axi.rvalid = hold_valid && !hold_write;
    assign axi.rid    = hold_id;
    assign axi.rdata  = hold_data;
    assign axi.bvalid = hold_valid && hold_write;
    assign axi.bid    = hold_id;

endmodule

/* hdl/sram_bank.sv */
`timescale 1ns/1ps

module sram_bank import mem_pkg::*; #(
    parameter int BANK_DEPTH = 64
) (
    input  logic  clk,
    input  logic  reset,
    bank_if.bank  port
);

    localparam int IDX_W = $clog2(BANK_DEPTH);

    logic [DATA_W-1:0] mem [BANK_DEPTH];
    logic [IDX_W-1:0]  idx;
    logic              accept;
    logic              full;
    logic              resp_write_q;
    logic [ID_W-1:0]   resp_id_q;
    logic [DATA_W-1:0] rdata_q;

    // Upper row bits are dropped, so addresses wrap
    assign idx    = port.row[IDX_W-1:0];
    assign accept = port.req_valid && !full;

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge clk) begin
        if (accept && port.req_write) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (port.strb[b]) begin
                    mem[idx][b*8 +: 8] <= port.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Response register payload
    always_ff @(posedge clk) begin
        if (accept) begin
            resp_write_q <= port.req_write;
            resp_id_q    <= port.req_id;
            if (!port.req_write) begin
                rdata_q <= mem[idx];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (port.resp_ready) begin
            full <= 1'b0;
        end
    end

    assign port.req_ready  = !full;
    assign port.resp_valid = full;
    assign port.resp_write = resp_write_q;
    assign port.resp_id    = resp_id_q;
    assign port.rdata      = rdata_q;

endmodule

/* verif/mem_subsystem_properties.sv */
`timescale 1ns/1ps

module mem_subsystem_properties import mem_pkg::*; (
    input logic            clk,
    input logic            reset,
    input logic            arvalid,
    input logic            arready,
    input logic            awvalid,
    input logic            awready,
    input logic            rvalid,
    input logic            rready,
    input logic [ID_W-1:0] rid,
    input logic            wait_fetch,
    input logic            inst_resp,
    input logic            data_resp
);

    int fail_count = 0;

    // --------------------
    // Handshake rules
    // --------------------
    a_reset_quiet: assert property (@(posedge clk) reset |=> !arvalid && !awvalid)
        else begin
            $error("address valid raised right after reset");
            fail_count++;
        end

    a_ar_hold: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid)
        else begin
            $error("arvalid dropped before arready");
            fail_count++;
        end

    a_aw_hold: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid)
        else begin
            $error("awvalid dropped before awready");
            fail_count++;
        end

    // Only one transfer in flight, so never two responses at once
    a_one_resp: assert property (@(posedge clk) disable iff (reset)
        !(inst_resp && data_resp))
        else begin
            $error("inst_resp and data_resp in the same cycle");
            fail_count++;
        end

    a_rid_match: assert property (@(posedge clk) disable iff (reset)
        rvalid && rready |-> rid == (wait_fetch ? ID_FETCH : ID_DATA))
        else begin
            $error("rid does not match the waiting state");
            fail_count++;
        end

endmodule

bind axi_arbiter mem_subsystem_properties props_i (
    .clk        (clk),
    .reset      (reset),
    .arvalid    (axi.arvalid),
    .arready    (axi.arready),
    .awvalid    (axi.awvalid),
    .awready    (axi.awready),
    .rvalid     (axi.rvalid),
    .rready     (axi.rready),
    .rid        (axi.rid),
    .wait_fetch (state == WAIT_FETCH),
    .inst_resp  (inst_resp),
    .data_resp  (data_resp)
);

/* verif/mem_subsystem_tb.sv */
`timescale 1ns/1ps

module mem_subsystem_tb import mem_pkg::*; ();

    localparam int NUM_BANKS   = 4;
    localparam int BANK_DEPTH  = 64;
    localparam int CAP_WORDS   = NUM_BANKS * BANK_DEPTH;
    localparam int POOL_BASE   = 100;
    // 300 operations at 8 cycles each, plus margin
    localparam int CYCLE_LIMIT = 300 * 8 + 600;

    logic              clk = 1'b0;
    logic              reset;
    logic              inst_en;
    logic [ADDR_W-1:0] inst_addr;
    logic              inst_resp;
    logic [DATA_W-1:0] inst_rdata;
    logic              data_en;
    logic [STRB_W-1:0] data_wen;
    logic [ADDR_W-1:0] data_addr;
    logic [DATA_W-1:0] data_wdata;
    logic              data_resp;
    logic [DATA_W-1:0] data_rdata;

    logic [DATA_W-1:0] shadow [int];
    logic [DATA_W-1:0] data_exp_q [$];
    bit                data_load_q [$];
    logic [DATA_W-1:0] inst_exp_q [$];
    logic [31:0]       rng = 32'd36;
    int cycles    = 0;
    int checks    = 0;
    int errors    = 0;
    int tests_ok  = 0;
    int tests_bad = 0;

    mem_subsystem #(.NUM_BANKS(NUM_BANKS), .BANK_DEPTH(BANK_DEPTH)) mem_subsystem_i (.*);

    always #2 clk = ~clk;

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [DATA_W-1:0] random_word();
        return {next_random(), next_random()};
    endfunction

    function automatic logic [ADDR_W-1:0] word_addr(input int word);
        return ADDR_W'(word * 8);
    endfunction

    // Word slot after the wrap over all banks
    function automatic int word_index(input logic [ADDR_W-1:0] addr);
        return int'((addr >> 3) % CAP_WORDS);
    endfunction

    // Shadow word with the strobed bytes replaced
    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr,
                                                        input logic [STRB_W-1:0] strb,
                                                        input logic [DATA_W-1:0] wdata);
        logic [DATA_W-1:0] word;
        int idx;
        idx  = word_index(addr);
        word = shadow.exists(idx) ? shadow[idx] : 'x;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                word[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return word;
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] got);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("error at %0t ns: %s expected %h got %h", $time, name, expected, got);
        end
    endtask

    // Drive one or both clients and hold each request until its resp
    task automatic access(input bit use_data, input logic [ADDR_W-1:0] addr,
                          input logic [STRB_W-1:0] wen, input logic [DATA_W-1:0] wdata,
                          input bit use_inst, input logic [ADDR_W-1:0] fetch_addr);
        logic [DATA_W-1:0] word;
        bit data_done;
        bit inst_done;
        data_done = !use_data;
        inst_done = !use_inst;
        if (use_data) begin
            word = expected_word(addr, wen, wdata);
            data_load_q.push_back(wen == '0);
            data_exp_q.push_back(word);
            if (wen != '0) begin
                shadow[word_index(addr)] = word;
            end
        end
        if (use_inst) begin
            inst_exp_q.push_back(expected_word(fetch_addr, '0, '0));
        end
        @(posedge clk);
        data_en    <= use_data;
        data_wen   <= wen;
        data_addr  <= addr;
        data_wdata <= wdata;
        inst_en    <= use_inst;
        inst_addr  <= fetch_addr;
        while (!(data_done && inst_done)) begin
            @(posedge clk);
            if (inst_resp && !data_done) begin
                errors++;
                $display("inst_resp at %0t ns came before the pending data_resp", $time);
            end
            if (data_resp) begin
                data_en   <= 1'b0;
                data_done = 1'b1;
            end
            if (inst_resp) begin
                inst_en   <= 1'b0;
                inst_done = 1'b1;
            end
        end
    endtask

    task automatic store_word(input logic [ADDR_W-1:0] addr, input logic [STRB_W-1:0] wen,
                              input logic [DATA_W-1:0] wdata);
        access(1'b1, addr, wen, wdata, 1'b0, '0);
    endtask

    task automatic load_word(input logic [ADDR_W-1:0] addr);
        access(1'b1, addr, '0, '0, 1'b0, '0);
    endtask

    task automatic fetch_word(input logic [ADDR_W-1:0] addr);
        access(1'b0, '0, '0, '0, 1'b1, addr);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    // --------------------
    // Response comparison
    // --------------------
    always @(posedge clk) begin
        if (data_resp) begin
            if (data_load_q.size() == 0) begin
                errors++;
                $display("data_resp pulsed at %0t ns with no data request pending", $time);
            end else if (data_load_q.pop_front()) begin
                check_value("data_rdata", data_exp_q.pop_front(), data_rdata);
            end else begin
                void'(data_exp_q.pop_front());
            end
        end
        if (inst_resp) begin
            if (inst_exp_q.size() == 0) begin
                errors++;
                $display("inst_resp pulsed at %0t ns with no fetch pending", $time);
            end else begin
                check_value("inst_rdata", inst_exp_q.pop_front(), inst_rdata);
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        logic [ADDR_W-1:0] addr;
        int base;
        int slot;
        int op;
        int props_fails;
        reset      = 1'b1;
        inst_en    = 1'b0;
        inst_addr  = '0;
        data_en    = 1'b0;
        data_wen   = '0;
        data_addr  = '0;
        data_wdata = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        base = errors;
        for (int b = 0; b < NUM_BANKS; b++) begin
            store_word(word_addr(NUM_BANKS * 5 + b), '1, random_word());
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            load_word(word_addr(NUM_BANKS * 5 + b));
        end
        finish_test("full stores and loads per bank", base);

        base = errors;
        for (int i = 0; i < NUM_BANKS; i++) begin
            store_word(word_addr(NUM_BANKS * 9 + i), '1, random_word());
            store_word(word_addr(NUM_BANKS * 9 + i), 8'h0F, random_word());
            store_word(word_addr(NUM_BANKS * 9 + i), 8'hA4, random_word());
            load_word(word_addr(NUM_BANKS * 9 + i));
        end
        finish_test("partial strobes", base);

        base = errors;
        for (int i = 0; i < NUM_BANKS; i++) begin
            fetch_word(word_addr(NUM_BANKS * 5 + i));
            fetch_word(word_addr(NUM_BANKS * 9 + i));
            store_word(word_addr(NUM_BANKS * 20 + i), '1, random_word());
            fetch_word(word_addr(NUM_BANKS * 20 + i));
        end
        finish_test("fetches of stored words", base);

        // Data goes first when both clients ask in the same idle cycle
        base = errors;
        access(1'b1, word_addr(NUM_BANKS * 5), '0, '0, 1'b1, word_addr(NUM_BANKS * 5 + 1));
        access(1'b1, word_addr(NUM_BANKS * 30 + 2), '1, random_word(),
               1'b1, word_addr(NUM_BANKS * 5 + 3));
        finish_test("simultaneous requests", base);

        base = errors;
        for (int s = 0; s < 16; s++) begin
            store_word(word_addr(POOL_BASE + s * 7), '1, random_word());
        end
        for (int n = 0; n < 200; n++) begin
            slot = int'(next_random() % 16);
            // Random bits above capacity must wrap onto the pool word
            addr = (next_random() & ~ADDR_W'(CAP_WORDS * 8 - 1)) |
                   word_addr(POOL_BASE + slot * 7);
            op   = int'(next_random() % 3);
            if (op == 0) begin
                load_word(addr);
            end else if (op == 1) begin
                store_word(addr, STRB_W'(next_random()) | STRB_W'(1), random_word());
            end else begin
                fetch_word(addr);
            end
        end
        finish_test("random mix with wrap", base);

        base = errors;
        @(posedge clk);
        reset <= 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        repeat (20) begin
            @(posedge clk);
            check_value("inst_resp", '0, inst_resp);
            check_value("data_resp", '0, data_resp);
        end
        finish_test("quiet after reset", base);

        props_fails = mem_subsystem_i.axi_arbiter_i.props_i.fail_count;
        $display("tests: %0d ok, %0d with errors; checks: %0d, errors: %0d, assertions: %0d",
                 tests_ok, tests_bad, checks, errors, props_fails);
        if (errors == 0 && props_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
hdl/mem_pkg.sv
hdl/mem_axi_if.sv
hdl/bank_if.sv
hdl/axi_arbiter.sv
hdl/bank_router.sv
hdl/sram_bank.sv
hdl/resp_merge.sv
hdl/mem_subsystem.sv
verif/mem_subsystem_properties.sv
verif/mem_subsystem_tb.sv
